/* source/emac_pkg.sv */
package emac_pkg;

  // Host bus and address widths
  localparam int ADR_W  = 11;
  localparam int DATA_W = 32;
  localparam int MAC_W  = 48;

  // Register map
  localparam logic [ADR_W-1:0] REG_STAT    = 11'h081;
  localparam logic [ADR_W-1:0] REG_MYMACL  = 11'h082;
  localparam logic [ADR_W-1:0] REG_MYMACH  = 11'h083;
  localparam logic [ADR_W-1:0] REG_BUF     = 11'h084;
  localparam logic [ADR_W-1:0] REG_STARTTX = 11'h086;
  localparam logic [ADR_W-1:0] REG_DSTL    = 11'h08A;
  localparam logic [ADR_W-1:0] REG_DSTH    = 11'h08B;
  localparam logic [ADR_W-1:0] REG_TYPE    = 11'h08C;

  // Payload buffer, count needs one bit more than the pointer
  localparam int BUF_DEPTH = 64;
  localparam int BUF_CNT_W = 7;

  // Preamble and start-of-frame delimiter
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam int         PREAMBLE_LEN  = 7;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // Destination, source and type bytes
  localparam int HDR_LEN = 14;

  // Reflected CRC-32 polynomial and start value
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

  // Host data word
  typedef logic [DATA_W-1:0] word_t;

  // One byte on the GMII transmit lines
  typedef logic [7:0] byte_t;

  typedef logic [MAC_W-1:0] mac_addr_t;

  typedef logic [15:0] ether_type_t;

endpackage

/* source/emac_regs.sv */
`timescale 1ns/1ps

module emac_regs import emac_pkg::*; (
  input  logic                 tx_clk_i,
  input  logic                 reset_i,
  input  logic                 wr_en_i,
  input  logic                 rd_en_i,
  input  logic [ADR_W-1:0]     adr_i,
  input  word_t                wr_data_i,
  output word_t                rd_data_o,
  input  logic                 busy_i,
  input  logic [BUF_CNT_W-1:0] buf_count_i,
  output logic                 buf_push_o,
  output word_t                buf_data_o,
  output logic                 start_o,
  output mac_addr_t            my_mac_o,
  output mac_addr_t            dst_mac_o,
  output ether_type_t          ether_type_o
);

  word_t stat_word;
  word_t rd_mux;
  logic  start_req;

  // Status word: busy in bit 0, fill level from bit 8
  always_comb begin
    stat_word = '0;
    stat_word[0] = busy_i;
    stat_word[8 +: BUF_CNT_W] = buf_count_i;
  end

  // Payload goes straight to the buffer, only while idle
  assign buf_push_o = wr_en_i && (adr_i == REG_BUF) && !busy_i;
  assign buf_data_o = wr_data_i;

  // Start only when idle and there is something to send
  assign start_req = wr_en_i && (adr_i == REG_STARTTX) && !busy_i &&
                     (buf_count_i != '0);

  // Address and type registers
  always_ff @(posedge tx_clk_i or negedge reset_i) begin
    if (!reset_i) begin
      my_mac_o     <= '0;
      dst_mac_o    <= '0;
      ether_type_o <= '0;
    end else if (wr_en_i) begin
      case (adr_i)
        REG_MYMACL: my_mac_o[31:0]   <= wr_data_i;
        REG_MYMACH: my_mac_o[47:32]  <= wr_data_i[15:0];
        REG_DSTL:   dst_mac_o[31:0]  <= wr_data_i;
        REG_DSTH:   dst_mac_o[47:32] <= wr_data_i[15:0];
        REG_TYPE:   ether_type_o     <= wr_data_i[15:0];
        default: ;
      endcase
    end
  end

  // One-cycle start pulse, a cycle after the strobe
  always_ff @(posedge tx_clk_i or negedge reset_i) begin
    if (!reset_i) begin
      start_o <= 1'b0;
    end else begin
      start_o <= start_req;
    end
  end

  // Read mux, unmapped and write-only addresses give zero
  always_comb begin
    rd_mux = '0;
    case (adr_i)
      REG_STAT:   rd_mux = stat_word;
      REG_MYMACL: rd_mux = my_mac_o[31:0];
      REG_MYMACH: rd_mux[15:0] = my_mac_o[47:32];
      REG_DSTL:   rd_mux = dst_mac_o[31:0];
      REG_DSTH:   rd_mux[15:0] = dst_mac_o[47:32];
      REG_TYPE:   rd_mux[15:0] = ether_type_o;
      default: ;
    endcase
  end

  // Read data held until the next read strobe
  always_ff @(posedge tx_clk_i or negedge reset_i) begin
    if (!reset_i) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= rd_mux;
    end
  end

endmodule

/* source/emac_tx_buffer.sv */
`timescale 1ns/1ps

module emac_tx_buffer import emac_pkg::*; #(
  parameter int DEPTH = BUF_DEPTH
) (
  input  logic                 tx_clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  word_t                data_i,
  input  logic                 pop_i,
  output word_t                head_o,
  output logic [BUF_CNT_W-1:0] count_o
);

  localparam int PTR_W = $clog2(DEPTH);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  // Full buffer drops the word, empty one ignores a pop
  assign do_push = push_i && (count_o != DEPTH[BUF_CNT_W-1:0]);
  assign do_pop  = pop_i && (count_o != '0);

  // Word store
  always_ff @(posedge tx_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Head word seen by the framer without delay
  assign head_o = mem[rd_ptr];

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge tx_clk_i or negedge reset_i) begin
    if (!reset_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

/* source/emac_crc32.sv */
`timescale 1ns/1ps

module emac_crc32 import emac_pkg::*; (
  input  logic  tx_clk_i,
  input  logic  reset_i,
  input  logic  clear_i,
  input  logic  en_i,
  input  byte_t data_i,
  output word_t crc_o
);

  // One byte through the reflected LFSR, bit 0 first
  function automatic word_t crc_step(word_t crc, byte_t d);
    word_t c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // Clear wins over a byte in the same cycle
  always_ff @(posedge tx_clk_i or negedge reset_i) begin
    if (!reset_i) begin
      crc_o <= CRC_INIT;
    end else if (clear_i) begin
      crc_o <= CRC_INIT;
    end else if (en_i) begin
      crc_o <= crc_step(crc_o, data_i);
    end
  end

endmodule

/* source/emac_tx_framer.sv */
`timescale 1ns/1ps

module emac_tx_framer import emac_pkg::*; (
  input  logic                 tx_clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  mac_addr_t            my_mac_i,
  input  mac_addr_t            dst_mac_i,
  input  ether_type_t          ether_type_i,
  input  word_t                buf_head_i,
  input  logic [BUF_CNT_W-1:0] buf_count_i,
  output logic                 buf_pop_o,
  input  word_t                crc_i,
  output logic                 crc_clear_o,
  output logic                 crc_en_o,
  output byte_t                crc_data_o,
  output logic                 busy_o,
  output logic                 tx_en_o,
  output byte_t                tx_d_o
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_PRE, ST_SFD, ST_HDR, ST_PAY, ST_FCS
  } state_t;

  state_t       state_q;
  state_t       state_d;
  logic [3:0]   cnt_q;
  logic [3:0]   cnt_d;
  logic         tx_en_d;
  byte_t        tx_d_d;
  logic [111:0] hdr;
  logic [3:0]   hdr_next;
  logic [3:0]   hdr_sel;
  logic [1:0]   pay_next;
  logic [1:0]   fcs_next;
  byte_t        hdr_byte;
  byte_t        pay_byte;
  byte_t        fcs_byte;

  // cnt_q indexes the byte now on the line, the *_next values the one after it
  assign hdr      = {dst_mac_i, my_mac_i, ether_type_i};
  assign hdr_next = (state_q == ST_HDR) ? cnt_q + 4'd1 : 4'd0;
  // Header goes out high byte first
  assign hdr_sel  = 4'd13 - hdr_next;
  assign hdr_byte = hdr[{hdr_sel, 3'b000} +: 8];

  // Payload MSB first, index wraps into the next word
  assign pay_next = (state_q == ST_PAY) ? cnt_q[1:0] + 2'd1 : 2'd0;
  assign pay_byte = buf_head_i[{~pay_next, 3'b000} +: 8];

  // FCS is the inverted CRC, low byte first
  assign fcs_next = (state_q == ST_FCS) ? cnt_q[1:0] + 2'd1 : 2'd0;
  assign fcs_byte = ~crc_i[{fcs_next, 3'b000} +: 8];

  // Start pulse already counts as busy so the host sees it a cycle early
  assign busy_o     = (state_q != ST_IDLE) || start_i;
  // CRC sees exactly the bytes registered for header and payload
  assign crc_data_o = tx_d_d;

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    tx_en_d     = tx_en_o;
    tx_d_d      = tx_d_o;
    crc_clear_o = 1'b0;
    crc_en_o    = 1'b0;
    buf_pop_o   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d     = ST_PRE;
          cnt_d       = '0;
          tx_en_d     = 1'b1;
          tx_d_d      = PREAMBLE_BYTE;
          crc_clear_o = 1'b1;
        end
      end
      ST_PRE: begin
        if (cnt_q == PREAMBLE_LEN - 1) begin
          state_d = ST_SFD;
          tx_d_d  = SFD_BYTE;
        end else begin
          cnt_d  = cnt_q + 4'd1;
          tx_d_d = PREAMBLE_BYTE;
        end
      end
      ST_SFD: begin
        state_d  = ST_HDR;
        cnt_d    = '0;
        tx_d_d   = hdr_byte;
        crc_en_o = 1'b1;
      end
      ST_HDR: begin
        crc_en_o = 1'b1;
        if (cnt_q == HDR_LEN - 1) begin
          state_d = ST_PAY;
          cnt_d   = '0;
          tx_d_d  = pay_byte;
        end else begin
          cnt_d  = cnt_q + 4'd1;
          tx_d_d = hdr_byte;
        end
      end
      ST_PAY: begin
        // Pop as the last byte of the word is taken
        buf_pop_o = (cnt_q[1:0] == 2'd2);
        if (cnt_q[1:0] == 2'd3 && buf_count_i == '0) begin
          state_d = ST_FCS;
          cnt_d   = '0;
          tx_d_d  = fcs_byte;
        end else begin
          cnt_d    = {2'b00, pay_next};
          tx_d_d   = pay_byte;
          crc_en_o = 1'b1;
        end
      end
      ST_FCS: begin
        if (cnt_q[1:0] == 2'd3) begin
          state_d = ST_IDLE;
          tx_en_d = 1'b0;
          tx_d_d  = '0;
        end else begin
          cnt_d  = cnt_q + 4'd1;
          tx_d_d = fcs_byte;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Line outputs registered on the transmit clock
  always_ff @(posedge tx_clk_i or negedge reset_i) begin
    if (!reset_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      tx_en_o <= 1'b0;
      tx_d_o  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      tx_en_o <= tx_en_d;
      tx_d_o  <= tx_d_d;
    end
  end

endmodule

/* source/emac_tx_top.sv */
`timescale 1ns/1ps

module emac_tx_top import emac_pkg::*; (
  input  logic             tx_clk_i,
  input  logic             reset_i,
  input  logic             wr_en_i,
  input  logic             rd_en_i,
  input  logic [ADR_W-1:0] adr_i,
  input  word_t            wr_data_i,
  output word_t            rd_data_o,
  output logic             tx_en_o,
  output byte_t            tx_d_o
);

  logic                 busy;
  logic                 start;
  logic                 buf_push;
  logic                 buf_pop;
  logic [BUF_CNT_W-1:0] buf_count;
  word_t                buf_data;
  word_t                buf_head;
  mac_addr_t            my_mac;
  mac_addr_t            dst_mac;
  ether_type_t          ether_type;
  logic                 crc_clear;
  logic                 crc_en;
  byte_t                crc_data;
  word_t                crc;

  // Host registers
  emac_regs i_regs (
    .tx_clk_i     (tx_clk_i),
    .reset_i      (reset_i),
    .wr_en_i      (wr_en_i),
    .rd_en_i      (rd_en_i),
    .adr_i        (adr_i),
    .wr_data_i    (wr_data_i),
    .rd_data_o    (rd_data_o),
    .busy_i       (busy),
    .buf_count_i  (buf_count),
    .buf_push_o   (buf_push),
    .buf_data_o   (buf_data),
    .start_o      (start),
    .my_mac_o     (my_mac),
    .dst_mac_o    (dst_mac),
    .ether_type_o (ether_type)
  );

  // Payload words
  emac_tx_buffer #(
    .DEPTH (BUF_DEPTH)
  ) i_buf (
    .tx_clk_i (tx_clk_i),
    .reset_i  (reset_i),
    .push_i   (buf_push),
    .data_i   (buf_data),
    .pop_i    (buf_pop),
    .head_o   (buf_head),
    .count_o  (buf_count)
  );

  // Transmit FCS
  emac_crc32 i_crc (
    .tx_clk_i (tx_clk_i),
    .reset_i  (reset_i),
    .clear_i  (crc_clear),
    .en_i     (crc_en),
    .data_i   (crc_data),
    .crc_o    (crc)
  );

  emac_tx_framer i_framer (
    .tx_clk_i     (tx_clk_i),
    .reset_i      (reset_i),
    .start_i      (start),
    .my_mac_i     (my_mac),
    .dst_mac_i    (dst_mac),
    .ether_type_i (ether_type),
    .buf_head_i   (buf_head),
    .buf_count_i  (buf_count),
    .buf_pop_o    (buf_pop),
    .crc_i        (crc),
    .crc_clear_o  (crc_clear),
    .crc_en_o     (crc_en),
    .crc_data_o   (crc_data),
    .busy_o       (busy),
    .tx_en_o      (tx_en_o),
    .tx_d_o       (tx_d_o)
  );

endmodule

/* tb/emac_tx_clkgen.sv */
`timescale 1ns/1ps

module emac_tx_clkgen (
  output logic clk_o,
  output logic reset_o
);

  // 10 ns transmit clock
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held low for the first 5 cycles
  initial begin
    reset_o = 1'b0;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b1;
  end

endmodule

/* tb/emac_tx_tb.sv */
`timescale 1ns/1ps

module emac_tx_tb import emac_pkg::*; ();

  localparam int CYCLE_LIMIT = 20000;

  logic             tx_clk;
  logic             reset_n;
  logic             wr_en;
  logic             rd_en;
  logic [ADR_W-1:0] adr;
  logic [31:0]      wr_data;
  logic [31:0]      rd_data;
  logic             tx_en;
  logic [7:0]       tx_d;

  // Reference header values mirrored from host writes
  logic [47:0] my_mac;
  logic [47:0] dst_mac;
  logic [15:0] eth_type;
  logic [31:0] pay_q[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  rx_q[$];
  logic [31:0] lfsr = 32'h6d82_7fc9;
  string       test_name = "reset";
  int          frames_done = 0;
  int          frames_started = 0;
  int          cycles = 0;
  logic        in_frame = 1'b0;

  emac_tx_clkgen i_clkgen (
    .clk_o   (tx_clk),
    .reset_o (reset_n)
  );

  emac_tx_top i_dut (
    .tx_clk_i  (tx_clk),
    .reset_i   (reset_n),
    .wr_en_i   (wr_en),
    .rd_en_i   (rd_en),
    .adr_i     (adr),
    .wr_data_i (wr_data),
    .rd_data_o (rd_data),
    .tx_en_o   (tx_en),
    .tx_d_o    (tx_d)
  );

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic fail_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    stop_on_failure($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                              test_name, what, exp, act));
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Non-reflected CRC-32 register fed with line bits LSB first
  function automatic logic [31:0] crc_feed(input logic [31:0] n, input logic [7:0] d);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = n;
    for (i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];
      r = {r[30:0], 1'b0};
      if (fb) begin
        r = r ^ 32'h04C1_1DB7;
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] bit_reverse(input logic [31:0] v);
    logic [31:0] r;
    int          i;
    for (i = 0; i < 32; i++) begin
      r[i] = v[31 - i];
    end
    return r;
  endfunction

  // Expected line bytes for the current header and pay_q
  task automatic build_expected();
    logic [31:0] n;
    logic [31:0] fcs;
    int          i;
    int          b;
    exp_q.delete();
    repeat (7) exp_q.push_back(8'h55);
    exp_q.push_back(8'hD5);
    for (b = 5; b >= 0; b--) exp_q.push_back(dst_mac[8*b +: 8]);
    for (b = 5; b >= 0; b--) exp_q.push_back(my_mac[8*b +: 8]);
    exp_q.push_back(eth_type[15:8]);
    exp_q.push_back(eth_type[7:0]);
    for (i = 0; i < pay_q.size(); i++) begin
      for (b = 3; b >= 0; b--) exp_q.push_back(pay_q[i][8*b +: 8]);
    end
    // CRC covers everything after the SFD
    n = 32'hFFFF_FFFF;
    for (i = 8; i < exp_q.size(); i++) begin
      n = crc_feed(n, exp_q[i]);
    end
    fcs = ~bit_reverse(n);
    for (b = 0; b < 4; b++) exp_q.push_back(fcs[8*b +: 8]);
  endtask

  task automatic bus_write(input logic [ADR_W-1:0] a, input logic [31:0] d);
    @(posedge tx_clk);
    wr_en   <= 1'b1;
    adr     <= a;
    wr_data <= d;
    @(posedge tx_clk);
    wr_en   <= 1'b0;
  endtask

  task automatic bus_read(input logic [ADR_W-1:0] a, output logic [31:0] d);
    @(posedge tx_clk);
    rd_en <= 1'b1;
    adr   <= a;
    @(posedge tx_clk);
    rd_en <= 1'b0;
    @(negedge tx_clk);
    d = rd_data;
  endtask

  task automatic read_expect(input logic [ADR_W-1:0] a, input logic [31:0] exp,
                             input string what);
    logic [31:0] d;
    bus_read(a, d);
    assert (d == exp) else fail_value(what, exp, d);
  endtask

  // Fill the buffer from pay_q and check the reported level
  task automatic load_payload();
    int i;
    for (i = 0; i < pay_q.size(); i++) begin
      bus_write(REG_BUF, pay_q[i]);
    end
    read_expect(REG_STAT, pay_q.size() << 8, "status before start");
  endtask

  // Start write with tx_en rising at the second edge after it
  task automatic start_frame();
    rx_q.delete();
    frames_started++;
    bus_write(REG_STARTTX, 32'h1);
    @(negedge tx_clk);
    assert (tx_en == 1'b0) else fail_value("tx_en one edge after start", 0, tx_en);
    @(negedge tx_clk);
    assert (tx_en == 1'b1) else fail_value("tx_en two edges after start", 1, tx_en);
    assert (tx_d == 8'h55) else fail_value("first preamble byte", 8'h55, tx_d);
  endtask

  task automatic finish_frame();
    int i;
    while (frames_done != frames_started) @(negedge tx_clk);
    build_expected();
    assert (rx_q.size() == 26 + 4 * pay_q.size())
      else fail_value("tx_en cycles", 26 + 4 * pay_q.size(), rx_q.size());
    for (i = 0; i < exp_q.size(); i++) begin
      assert (rx_q[i] == exp_q[i])
        else fail_value($sformatf("line byte %0d", i), exp_q[i], rx_q[i]);
    end
    read_expect(REG_STAT, 32'h0, "status after frame");
  endtask

  // Line monitor collecting bytes while tx_en is high
  always @(negedge tx_clk) begin
    if (reset_n) begin
      if (tx_en) begin
        rx_q.push_back(tx_d);
        in_frame = 1'b1;
      end else begin
        assert (tx_d == 8'h00) else fail_value("idle tx_d", 0, tx_d);
        if (in_frame) begin
          in_frame = 1'b0;
          frames_done++;
        end
      end
    end
  end

  // Hang guard
  always @(posedge tx_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      stop_on_failure($sformatf("Run stopped by timeout after %0d cycles", cycles));
    end
  end

  initial begin
    logic [31:0] stat;
    int          n;
    int          f;
    int          i;
    wr_en   <= 1'b0;
    rd_en   <= 1'b0;
    adr     <= '0;
    wr_data <= '0;
    @(posedge reset_n);
    @(posedge tx_clk);

    // Everything zero out of reset
    assert (tx_en == 1'b0) else fail_value("tx_en after reset", 0, tx_en);
    read_expect(REG_STAT, 32'h0, "status");
    read_expect(REG_MYMACL, 32'h0, "own mac low");
    read_expect(REG_MYMACH, 32'h0, "own mac high");
    read_expect(REG_DSTL, 32'h0, "dest mac low");
    read_expect(REG_DSTH, 32'h0, "dest mac high");
    read_expect(REG_TYPE, 32'h0, "type");

    // High registers keep only 16 bits on readback
    test_name = "register readback";
    my_mac   = 48'h0200_5e10_2030;
    dst_mac  = 48'ha4c1_3857_9bde;
    eth_type = 16'h0800;
    bus_write(REG_MYMACL, my_mac[31:0]);
    bus_write(REG_MYMACH, {16'hffff, my_mac[47:32]});
    bus_write(REG_DSTL, dst_mac[31:0]);
    bus_write(REG_DSTH, {16'h1234, dst_mac[47:32]});
    bus_write(REG_TYPE, {16'habcd, eth_type});
    read_expect(REG_MYMACL, my_mac[31:0], "own mac low");
    read_expect(REG_MYMACH, {16'h0, my_mac[47:32]}, "own mac high");
    read_expect(REG_DSTL, dst_mac[31:0], "dest mac low");
    read_expect(REG_DSTH, {16'h0, dst_mac[47:32]}, "dest mac high");
    read_expect(REG_TYPE, {16'h0, eth_type}, "type");
    read_expect(11'h000, 32'h0, "unmapped 0x000");
    read_expect(11'h085, 32'h0, "unmapped 0x085");
    read_expect(REG_STARTTX, 32'h0, "start register");
    read_expect(11'h7ff, 32'h0, "unmapped 0x7ff");

    test_name = "fixed frame";
    pay_q = '{32'h0011_2233, 32'h4455_6677, 32'h8899_aabb};
    load_payload();
    start_frame();
    finish_frame();

    // Start and payload writes while busy must be dropped
    test_name = "busy frame";
    pay_q = '{32'hcafe_0001, 32'hcafe_0002, 32'hcafe_0003, 32'hcafe_0004};
    load_payload();
    start_frame();
    bus_read(REG_STAT, stat);
    assert (stat[0] == 1'b1) else fail_value("busy during frame", 1, stat[0]);
    bus_write(REG_STARTTX, 32'h1);
    bus_write(REG_BUF, 32'hdead_beef);
    finish_frame();
    repeat (100) @(negedge tx_clk);
    assert (frames_done == frames_started)
      else fail_value("frame count", frames_started, frames_done);

    // Start with nothing buffered sends nothing
    test_name = "empty start";
    bus_write(REG_STARTTX, 32'h1);
    read_expect(REG_STAT, 32'h0, "status after empty start");
    for (i = 0; i < 100; i++) begin
      @(negedge tx_clk);
      assert (tx_en == 1'b0) else fail_value("tx_en after empty start", 0, tx_en);
    end

    for (f = 0; f < 5; f++) begin
      test_name = $sformatf("random frame %0d", f);
      eth_type = rand_bits(16);
      bus_write(REG_TYPE, {16'h0, eth_type});
      n = 1 + rand_bits(4);
      pay_q.delete();
      for (i = 0; i < n; i++) begin
        pay_q.push_back(rand_bits(32));
      end
      load_payload();
      start_frame();
      finish_frame();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* emac_tx_top.f */
source/emac_pkg.sv
source/emac_regs.sv
source/emac_tx_buffer.sv
source/emac_crc32.sv
source/emac_tx_framer.sv
source/emac_tx_top.sv
tb/emac_tx_clkgen.sv
tb/emac_tx_tb.sv
